//--- logic/ucode_params.svh
// Holds widths and codes for KLX.RAM C records and KL10 CRAM diagnostic writes only
`ifndef UCODE_PARAMS_SVH
`define UCODE_PARAMS_SVH

//////////////////////////////////////////////////
// Widths
`define UCODE_CHAR_W          7
`define UCODE_WORD_W          16
`define UCODE_EBUS_W          36
`define UCODE_CRAM_W          86
`define UCODE_CRAM_ADR_W      11
`define UCODE_DIAG_W          7

// Six load-file words per CRAM word and at most five CRAM words per line
`define UCODE_WORDS_PER_CRAM  6
`define UCODE_MAX_WC          30
`define UCODE_WRITES_PER_CRAM 7

//////////////////////////////////////////////////
// Diagnostic function codes for CRAM loading
`define UCODE_DF_ADR_LH       7'o51
`define UCODE_DF_ADR_RH       7'o52
`define UCODE_DF_WR_80_85     7'o53
`define UCODE_DF_WR_60_79     7'o54
`define UCODE_DF_WR_40_59     7'o55
`define UCODE_DF_WR_20_39     7'o56
`define UCODE_DF_WR_00_19     7'o57

// Microcode version lives in these two CRAM words
`define UCODE_VER_ADR_LO      11'o136
`define UCODE_VER_ADR_HI      11'o137

//////////////////////////////////////////////////
// Character codes and the ASCIIized range
`define UCODE_CH_NL           7'o012
`define UCODE_CH_CR           7'o015
`define UCODE_CH_SPACE        7'o040
`define UCODE_CH_COMMA        7'o054
`define UCODE_CH_SEMI         7'o073
`define UCODE_CH_C            7'o103
`define UCODE_CH_D            7'o104
`define UCODE_CH_Z            7'o132
`define UCODE_CH_ASCII_LO     7'o100
`define UCODE_CH_ASCII_HI     7'o175

`endif

//--- logic/ucodePkg.sv
// CRAM, address and EBUS vectors count bit 0 as the most significant bit as the KL10 does
`include "ucode_params.svh"

package ucodePkg;

  //////////////////////////////////////////////////
  // Plain vectors with a meaning

  // One decoded load-file word
  typedef logic [`UCODE_WORD_W-1:0] word_t;

  // EBUS data, bit 0 on the left
  typedef logic [0:`UCODE_EBUS_W-1] ebusData_t;

  // Control word, bits 0 to 85
  typedef logic [0:`UCODE_CRAM_W-1] cramWord_t;

  // CRAM address, bits 0 to 10
  typedef logic [0:`UCODE_CRAM_ADR_W-1] cramAdr_t;

  // Diagnostic function select
  typedef logic [`UCODE_DIAG_W-1:0] diagFunc_t;

  //////////////////////////////////////////////////
  // Record type from the first character of a line
  typedef enum logic [1:0] {
    CRAM,
    SKIP,
    BAD
  } recType_t;

  // Decoder token, one per comma or newline
  typedef struct packed {
    word_t    value;
    logic     lineEnd;
    recType_t recType;
  } wordTok_t;

  // One complete CRAM word and where it goes
  typedef struct packed {
    cramAdr_t  adr;
    cramWord_t word;
  } cramWrite_t;

  // Diagnostic side of the EBUS as driven by the front end
  typedef struct packed {
    diagFunc_t func;
    logic      diagStrobe;
    logic      driving;
    ebusData_t data;
  } diagBus_t;

  // Microcode version as major.minor(edit)
  typedef struct packed {
    logic [5:0] major;
    logic [2:0] minor;
    logic [8:0] edit;
  } cramVersion_t;

endpackage

//--- logic/sixbitDecoder.sv
// Expects one record per line ended by newline and ignores empty lines
`timescale 1ns/1ps
`include "ucode_params.svh"

module sixbitDecoder (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     charValid,
  input  logic [`UCODE_CHAR_W-1:0] charIn,
  output logic                     charReady,
  input  logic                     stall,
  output logic                     tokValid,
  output ucodePkg::wordTok_t       tok
);

  // Where we are within the current line
  typedef enum logic [1:0] {
    posType,
    posSep,
    posBody
  } linePos_t;

  linePos_t           pos;
  ucodePkg::recType_t lineType;
  ucodePkg::recType_t charType;
  ucodePkg::word_t    acc;
  logic [6:0]         fieldVal;
  logic               take;
  logic               isNl;
  logic               endsWord;

  // Parser back-pressure goes straight to the source
  assign charReady = !stall;
  assign take      = charValid && charReady;
  assign isNl      = (charIn == `UCODE_CH_NL);
  assign endsWord  = isNl || (pos == posBody && charIn == `UCODE_CH_COMMA);

  // Six-bit field value of one character
  always_comb begin
    if (charIn >= `UCODE_CH_ASCII_LO && charIn <= `UCODE_CH_ASCII_HI) begin
      fieldVal = {1'b0, charIn[5:0]};
    end else begin
      fieldVal = charIn;
    end
  end

  // Record type letter
  always_comb begin
    case (charIn)
      `UCODE_CH_C:    charType = ucodePkg::CRAM;
      `UCODE_CH_D,
      `UCODE_CH_Z,
      `UCODE_CH_SEMI: charType = ucodePkg::SKIP;
      default:        charType = ucodePkg::BAD;
    endcase
  end

  //////////////////////////////////////////////////
  // Line position and token output
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pos      <= posType;
      lineType <= ucodePkg::SKIP;
      tokValid <= 1'b0;
    end else begin
      tokValid <= 1'b0;
      if (take) begin
        if (pos == posType) begin
          // Blank line leaves us waiting for a type letter
          if (!isNl) begin
            lineType <= charType;
            pos      <= posSep;
          end
        end else if (endsWord) begin
          tokValid <= 1'b1;
          if (isNl) begin
            pos <= posType;
          end
        end else if (pos == posSep) begin
          // Separator after the type letter is dropped
          pos <= posBody;
        end
      end
    end
  end

  // Word accumulator and token payload
  always_ff @(posedge clk) begin
    if (take) begin
      if (pos == posType) begin
        acc <= '0;
      end else if (endsWord) begin
        tok.value   <= acc;
        tok.lineEnd <= isNl;
        tok.recType <= lineType;
        acc         <= '0;
      end else if (pos == posBody && charIn != `UCODE_CH_SPACE &&
                   charIn != `UCODE_CH_CR) begin
        // Most significant field arrives first
        acc <= (acc << 6) | ucodePkg::word_t'(fieldVal);
      end
    end
  end

endmodule

//--- logic/recordParser.sv
// Parses C lines only and does not take back CRAM writes made before a bad checksum
`timescale 1ns/1ps
`include "ucode_params.svh"

module recordParser (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 tokValid,
  input  ucodePkg::wordTok_t   tok,
  output logic                 stall,
  output logic                 cwValid,
  output ucodePkg::cramWrite_t cw,
  input  logic                 cwReady,
  output logic                 loadDone,
  output logic                 cksumErr,
  output logic                 formatErr
);

  typedef enum logic [2:0] {
    stWc,
    stAdr,
    stData,
    stCksum,
    stDrain
  } parseState_t;

  parseState_t         state;
  ucodePkg::word_t     sum;
  ucodePkg::word_t     sumNext;
  logic [4:0]          wc;
  logic [4:0]          rem;
  logic [2:0]          slot;
  ucodePkg::cramAdr_t  curAdr;
  logic [0:79]         asmWord;
  logic                drainErr;
  logic                drainDone;
  logic                wcOk;
  logic                toDrain;
  logic                lineErr;
  logic                lineDone;
  logic                advance;
  logic                lastSlot;

  // Hold the character stream while a word waits for the writer
  assign stall    = cwValid;
  assign sumNext  = sum + tok.value;
  assign advance  = tokValid && !toDrain;
  assign lastSlot = (slot == 3'(`UCODE_WORDS_PER_CRAM - 1));

  // Word count must be whole CRAM words and fit one line
  assign wcOk = (tok.value <= `UCODE_MAX_WC) && (tok.value % `UCODE_WORDS_PER_CRAM == 0);

  //////////////////////////////////////////////////
  // Decide whether this token ends the useful part of the line
  always_comb begin
    toDrain  = 1'b0;
    lineErr  = 1'b0;
    lineDone = 1'b0;
    case (state)
      stWc: begin
        if (tok.recType != ucodePkg::CRAM) begin
          toDrain = 1'b1;
          lineErr = (tok.recType == ucodePkg::BAD);
        end else if (tok.lineEnd || (tok.value != '0 && !wcOk)) begin
          toDrain = 1'b1;
          lineErr = 1'b1;
        end
      end
      stAdr: begin
        // Zero count with zero address is the end record
        if (wc == '0) begin
          toDrain  = 1'b1;
          lineDone = (tok.value == '0);
          lineErr  = (tok.value != '0);
        end else if (tok.lineEnd) begin
          toDrain = 1'b1;
          lineErr = 1'b1;
        end
      end
      stData: begin
        if (tok.lineEnd) begin
          toDrain = 1'b1;
          lineErr = 1'b1;
        end
      end
      // Words after the checksum
      stCksum: begin
        if (!tok.lineEnd) begin
          toDrain = 1'b1;
          lineErr = 1'b1;
        end
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Control state and one-cycle flags
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= stWc;
      rem       <= '0;
      slot      <= '0;
      curAdr    <= '0;
      cwValid   <= 1'b0;
      drainErr  <= 1'b0;
      drainDone <= 1'b0;
      loadDone  <= 1'b0;
      cksumErr  <= 1'b0;
      formatErr <= 1'b0;
    end else begin
      loadDone  <= 1'b0;
      cksumErr  <= 1'b0;
      formatErr <= 1'b0;
      if (cwValid && cwReady) begin
        cwValid <= 1'b0;
      end
      if (tokValid && toDrain) begin
        // A line end settles the flags at once
        if (tok.lineEnd) begin
          formatErr <= lineErr;
          loadDone  <= lineDone;
          state     <= stWc;
        end else begin
          drainErr  <= lineErr;
          drainDone <= lineDone;
          state     <= stDrain;
        end
      end else if (advance) begin
        case (state)
          stWc: state <= stAdr;
          stAdr: begin
            // Zero address continues after the last word written
            if (tok.value != '0) begin
              curAdr <= tok.value[`UCODE_CRAM_ADR_W-1:0];
            end
            rem   <= wc;
            slot  <= '0;
            state <= stData;
          end
          stData: begin
            slot <= lastSlot ? 3'd0 : slot + 3'd1;
            rem  <= rem - 5'd1;
            if (lastSlot) begin
              cwValid <= 1'b1;
              curAdr  <= curAdr + 1'b1;
            end
            if (rem == 5'd1) begin
              state <= stCksum;
            end
          end
          stCksum: begin
            cksumErr <= (sumNext != '0);
            state    <= stWc;
          end
          default: begin
            if (tok.lineEnd) begin
              formatErr <= drainErr;
              loadDone  <= drainDone;
              state     <= stWc;
            end
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Checksum, count and word assembly
  always_ff @(posedge clk) begin
    if (advance) begin
      sum <= (state == stWc) ? tok.value : sumNext;
      if (state == stWc) begin
        wc <= tok.value[4:0];
      end
      if (state == stData) begin
        case (slot)
          3'd0: asmWord[64:79] <= tok.value;
          3'd1: asmWord[48:63] <= tok.value;
          3'd2: asmWord[32:47] <= tok.value;
          3'd3: asmWord[16:31] <= tok.value;
          3'd4: asmWord[0:15]  <= tok.value;
          default: begin
            // Sixth word carries bits 80 to 85 in its low six bits
            cw.word <= {asmWord, tok.value[5:0]};
            cw.adr  <= curAdr;
          end
        endcase
      end
    end
  end

  // Offered word stays put until the writer takes it
  cwHeld: assert property (@(posedge clk) disable iff (!rstN)
    cwValid && !cwReady |=> cwValid && $stable(cw));

endmodule

//--- logic/cramWriter.sv
// Issues CRAM loads only and reports the version once addresses 136 and 137 are both written
`timescale 1ns/1ps
`include "ucode_params.svh"

module cramWriter (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   cwValid,
  input  ucodePkg::cramWrite_t   cw,
  output logic                   cwReady,
  output ucodePkg::diagBus_t     diag,
  output ucodePkg::cramVersion_t version,
  output logic                   versionValid
);

  // Four phases of one diagnostic write
  typedef enum logic [2:0] {
    stIdle,
    stStrobe1,
    stStrobe2,
    stDrive,
    stGap
  } phase_t;

  localparam logic [2:0] LastWrite = 3'(`UCODE_WRITES_PER_CRAM - 1);

  phase_t              state;
  logic [2:0]          writeIdx;
  ucodePkg::cramAdr_t  adr;
  ucodePkg::cramWord_t word;
  logic                take;
  logic                lastGap;
  logic                wordDone;
  logic                seen136;
  logic                seen137;

  // Next word may start right after the last gap
  assign lastGap  = (state == stGap) && (writeIdx == LastWrite);
  assign cwReady  = (state == stIdle) || lastGap;
  assign take     = cwValid && cwReady;
  assign wordDone = (state == stDrive) && (writeIdx == LastWrite);

  // Twenty CRAM bits in five nibbles with two-bit gaps
  function automatic ucodePkg::ebusData_t packNibbles(input ucodePkg::cramWord_t w,
                                                      input int base);
    packNibbles = {8'b0, w[base +: 4], 2'b0, w[base + 4 +: 4], 2'b0,
                   w[base + 8 +: 4], 2'b0, w[base + 12 +: 4], 2'b0,
                   w[base + 16 +: 4]};
  endfunction

  //////////////////////////////////////////////////
  // Function code and data scatter per write
  always_comb begin
    case (writeIdx)
      3'd0: begin
        diag.func = `UCODE_DF_ADR_RH;
        diag.data = {adr[5:10], 30'b0};
      end
      3'd1: begin
        diag.func = `UCODE_DF_ADR_LH;
        diag.data = {1'b0, adr[0:4], 30'b0};
      end
      3'd2: begin
        // Even bits only with wider gaps after 62, 66, 70 and 74
        diag.func = `UCODE_DF_WR_60_79;
        diag.data = {8'b0,
                     word[60], 1'b0, word[62], 3'b0, word[64], 1'b0,
                     word[66], 3'b0, word[68], 1'b0, word[70], 3'b0,
                     word[72], 1'b0, word[74], 3'b0, word[76], 1'b0,
                     word[78], 1'b0};
      end
      3'd3: begin
        diag.func = `UCODE_DF_WR_40_59;
        diag.data = packNibbles(word, 40);
      end
      3'd4: begin
        diag.func = `UCODE_DF_WR_20_39;
        diag.data = packNibbles(word, 20);
      end
      3'd5: begin
        diag.func = `UCODE_DF_WR_00_19;
        diag.data = packNibbles(word, 0);
      end
      default: begin
        diag.func = `UCODE_DF_WR_80_85;
        diag.data = {word[80:85], 30'b0};
      end
    endcase
    diag.diagStrobe = (state == stStrobe1) || (state == stStrobe2);
    diag.driving    = diag.diagStrobe || (state == stDrive);
  end

  //////////////////////////////////////////////////
  // Write sequencing
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= stIdle;
      writeIdx <= '0;
      seen136  <= 1'b0;
      seen137  <= 1'b0;
    end else begin
      case (state)
        stStrobe1: state <= stStrobe2;
        stStrobe2: state <= stDrive;
        stDrive:   state <= stGap;
        stGap: begin
          if (writeIdx != LastWrite) begin
            writeIdx <= writeIdx + 3'd1;
            state    <= stStrobe1;
          end else begin
            state <= stIdle;
          end
        end
        default: ;
      endcase
      if (take) begin
        writeIdx <= '0;
        state    <= stStrobe1;
      end
      // Version word counts once its last write is on the bus
      if (wordDone && adr == `UCODE_VER_ADR_LO) begin
        seen136 <= 1'b1;
      end
      if (wordDone && adr == `UCODE_VER_ADR_HI) begin
        seen137 <= 1'b1;
      end
    end
  end

  assign versionValid = seen136 && seen137;

  // Word payload and version fields
  always_ff @(posedge clk) begin
    if (take) begin
      adr  <= cw.adr;
      word <= cw.word;
    end
    if (wordDone && adr == `UCODE_VER_ADR_LO) begin
      version.major <= {word[29:31], word[33:35]};
      version.minor <= word[37:39];
    end
    if (wordDone && adr == `UCODE_VER_ADR_HI) begin
      version.edit <= {word[29:31], word[33:35], word[37:39]};
    end
  end

  // Two strobe cycles with the driver on, one driven cycle, then idle
  writeTiming: assert property (@(posedge clk) disable iff (!rstN)
    $rose(diag.diagStrobe) |-> diag.driving
      ##1 (diag.diagStrobe && diag.driving)
      ##1 (!diag.diagStrobe && diag.driving)
      ##1 !diag.driving);

  // Code and data hold for the whole driven span of one write
  driveStable: assert property (@(posedge clk) disable iff (!rstN)
    diag.driving |=> !diag.driving || ($stable(diag.func) && $stable(diag.data)));

endmodule

//--- logic/ucodeLoader.sv
// Loads CRAM only and expects the caller to reset before each new load file
`timescale 1ns/1ps
`include "ucode_params.svh"

module ucodeLoader (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     charValid,
  input  logic [`UCODE_CHAR_W-1:0] charIn,
  output logic                     charReady,
  output ucodePkg::diagBus_t       diag,
  output logic                     loadDone,
  output logic                     cksumErr,
  output logic                     formatErr,
  output ucodePkg::cramVersion_t   version,
  output logic                     versionValid
);

  // Decoder to parser
  logic                 stall;
  logic                 tokValid;
  ucodePkg::wordTok_t   tok;

  // Parser to writer
  logic                 cwValid;
  logic                 cwReady;
  ucodePkg::cramWrite_t cw;

  sixbitDecoder sixbitDecoder_i (
    .clk       (clk),
    .rstN      (rstN),
    .charValid (charValid),
    .charIn    (charIn),
    .charReady (charReady),
    .stall     (stall),
    .tokValid  (tokValid),
    .tok       (tok)
  );

  recordParser recordParser_i (
    .clk       (clk),
    .rstN      (rstN),
    .tokValid  (tokValid),
    .tok       (tok),
    .stall     (stall),
    .cwValid   (cwValid),
    .cw        (cw),
    .cwReady   (cwReady),
    .loadDone  (loadDone),
    .cksumErr  (cksumErr),
    .formatErr (formatErr)
  );

  cramWriter cramWriter_i (
    .clk          (clk),
    .rstN         (rstN),
    .cwValid      (cwValid),
    .cw           (cw),
    .cwReady      (cwReady),
    .diag         (diag),
    .version      (version),
    .versionValid (versionValid)
  );

endmodule

//--- tb/loadFileModel.svh
// Included inside the testbench module; every word is sent as three fields and data is random
`ifndef LOAD_FILE_MODEL_SVH
`define LOAD_FILE_MODEL_SVH

//////////////////////////////////////////////////
// Model state

// Characters of the line being built
logic [`UCODE_CHAR_W-1:0] lineChars[$];
// Bus writes still due, oldest first
ucodePkg::diagBus_t       expWrites[$];
ucodePkg::cramAdr_t       nextAdr;
ucodePkg::cramVersion_t   expVersion;
bit                       expSeenLo;
bit                       expSeenHi;
// Flags the current line should raise
bit                       expCksum;
bit                       expFormat;
bit                       expDone;
int                       lineCram;

// Character that carries one six-bit field
function automatic logic [`UCODE_CHAR_W-1:0] fieldChar(input logic [5:0] f);
  // Fields 076 and 077 lie below the ASCIIized range and stand for themselves
  if (f >= 6'o76) begin
    fieldChar = {1'b0, f};
  end else begin
    fieldChar = 7'o100 | {1'b0, f};
  end
endfunction

// Three fields then the word terminator
task automatic putWord(input ucodePkg::word_t w, input bit last);
  lineChars.push_back(fieldChar({2'b00, w[15:12]}));
  lineChars.push_back(fieldChar(w[11:6]));
  lineChars.push_back(fieldChar(w[5:0]));
  if (last) begin
    lineChars.push_back(`UCODE_CH_NL);
  end else begin
    lineChars.push_back(`UCODE_CH_COMMA);
  end
endtask

// Type letter and separator
task automatic startLine(input logic [`UCODE_CHAR_W-1:0] typeChar);
  lineChars.delete();
  lineChars.push_back(typeChar);
  lineChars.push_back(`UCODE_CH_SPACE);
  expCksum  = 1'b0;
  expFormat = 1'b0;
  expDone   = 1'b0;
  lineCram  = 0;
endtask

//////////////////////////////////////////////////
// Seven writes of one CRAM word with bit 0 as the leftmost EBUS bit
task automatic expectWrites(input ucodePkg::cramAdr_t a, input ucodePkg::cramWord_t w);
  ucodePkg::diagBus_t d;
  int                 i;
  int                 b;
  int                 k;
  int                 pos;
  int                 base;
  d.diagStrobe = 1'b1;
  d.driving    = 1'b1;
  // Low address half first
  d.func = `UCODE_DF_ADR_RH;
  d.data = '0;
  for (i = 0; i < 6; i++) begin
    d.data[i] = a[5 + i];
  end
  expWrites.push_back(d);
  d.func = `UCODE_DF_ADR_LH;
  d.data = '0;
  for (i = 0; i < 5; i++) begin
    d.data[1 + i] = a[i];
  end
  expWrites.push_back(d);
  // Even bits 60 to 78 with wide gaps after 62 66 70 74
  d.func = `UCODE_DF_WR_60_79;
  d.data = '0;
  pos    = 8;
  for (b = 60; b < 80; b += 2) begin
    d.data[pos] = w[b];
    pos += (b == 62 || b == 66 || b == 70 || b == 74) ? 4 : 2;
  end
  expWrites.push_back(d);
  // Three twenty-bit fields in nibbles with the highest field first
  for (k = 0; k < 3; k++) begin
    base   = 40 - 20 * k;
    d.func = (k == 0) ? `UCODE_DF_WR_40_59 : (k == 1) ? `UCODE_DF_WR_20_39 : `UCODE_DF_WR_00_19;
    d.data = '0;
    pos    = 8;
    for (i = 0; i < 20; i++) begin
      d.data[pos] = w[base + i];
      pos += (i % 4 == 3) ? 3 : 1;
    end
    expWrites.push_back(d);
  end
  d.func = `UCODE_DF_WR_80_85;
  d.data = '0;
  for (i = 0; i < 6; i++) begin
    d.data[i] = w[80 + i];
  end
  expWrites.push_back(d);
  // Version fields from the two fixed words
  if (a == `UCODE_VER_ADR_LO) begin
    expVersion.major = {w[29:31], w[33:35]};
    expVersion.minor = w[37:39];
    expSeenLo        = 1'b1;
  end
  if (a == `UCODE_VER_ADR_HI) begin
    expVersion.edit = {w[29:31], w[33:35], w[37:39]};
    expSeenHi       = 1'b1;
  end
endtask

//////////////////////////////////////////////////
// C line with nCram random words where a zero adr continues
task automatic buildCramLine(input ucodePkg::word_t adr, input int nCram, input bit corrupt);
  ucodePkg::word_t     sum;
  ucodePkg::word_t     v;
  ucodePkg::cramWord_t w;
  int                  c;
  int                  s;
  startLine(`UCODE_CH_C);
  v   = ucodePkg::word_t'(nCram * `UCODE_WORDS_PER_CRAM);
  sum = v + adr;
  putWord(v, 1'b0);
  putWord(adr, 1'b0);
  if (adr != '0) begin
    nextAdr = adr[10:0];
  end
  for (c = 0; c < nCram; c++) begin
    w = '0;
    for (s = 0; s < `UCODE_WORDS_PER_CRAM; s++) begin
      v = ucodePkg::word_t'($urandom);
      sum += v;
      putWord(v, 1'b0);
      case (s)
        0: w[64:79] = v;
        1: w[48:63] = v;
        2: w[32:47] = v;
        3: w[16:31] = v;
        4: w[0:15] = v;
        default: w[80:85] = v[5:0];
      endcase
    end
    expectWrites(nextAdr, w);
    nextAdr = nextAdr + 1'b1;
    lineCram++;
  end
  // Checksum brings the line sum to zero
  v = -sum;
  if (corrupt) begin
    v = v + ucodePkg::word_t'(1 + $urandom % 200);
  end
  putWord(v, 1'b1);
  expCksum = corrupt;
endtask

// D Z comment or unknown line with random words
task automatic buildOtherLine(input logic [`UCODE_CHAR_W-1:0] typeChar, input int nWords,
                              input bit isBad);
  int i;
  startLine(typeChar);
  for (i = 0; i < nWords; i++) begin
    putWord(ucodePkg::word_t'($urandom), i == nWords - 1);
  end
  expFormat = isBad;
endtask

// C line whose count is no multiple of six
task automatic buildBadCountLine();
  startLine(`UCODE_CH_C);
  putWord(ucodePkg::word_t'(6 * ($urandom % 5) + 1 + $urandom % 5), 1'b0);
  putWord(ucodePkg::word_t'($urandom), 1'b0);
  putWord(ucodePkg::word_t'($urandom), 1'b1);
  expFormat = 1'b1;
endtask

// End record has zero count and zero address
task automatic buildEndLine();
  startLine(`UCODE_CH_C);
  putWord('0, 1'b0);
  putWord('0, 1'b0);
  putWord('0, 1'b1);
  expDone = 1'b1;
endtask

`endif

//--- tb/ucodeLoaderTb.sv
// Runs one load file per reset and stops at the first mismatch; needs simulator timing support
`timescale 1ns/1ps
`include "ucode_params.svh"

module ucodeLoaderTb;

  logic                     clk;
  logic                     rstN;
  logic                     charValid;
  logic [`UCODE_CHAR_W-1:0] charIn;
  logic                     charReady;
  ucodePkg::diagBus_t       diag;
  logic                     loadDone;
  logic                     cksumErr;
  logic                     formatErr;
  ucodePkg::cramVersion_t   version;
  logic                     versionValid;

  string testName;
  int    cycles     = 0;
  int    cycleLimit = 200;
  int    cksumCnt   = 0;
  int    formatCnt  = 0;
  int    doneCnt    = 0;
  // Cycles since the current write started, 3 once it is over
  int    writePhase = 3;
  int    n;

  `include "loadFileModel.svh"

  ucodeLoader ucodeLoader_i (
    .clk          (clk),
    .rstN         (rstN),
    .charValid    (charValid),
    .charIn       (charIn),
    .charReady    (charReady),
    .diag         (diag),
    .loadDone     (loadDone),
    .cksumErr     (cksumErr),
    .formatErr    (formatErr),
    .version      (version),
    .versionValid (versionValid)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Failure exit and compare tasks
  task automatic abortRun();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkDiag(input ucodePkg::diagBus_t exp, input ucodePkg::diagBus_t act);
    if (act !== exp) begin
      $display("ERR %s bus write expected %h actual %h", testName, exp, act);
      abortRun();
    end
  endtask

  task automatic checkVersion(input ucodePkg::cramVersion_t exp,
                              input ucodePkg::cramVersion_t act);
    if (act !== exp) begin
      $display("ERR %s version expected %h actual %h", testName, exp, act);
      abortRun();
    end
  endtask

  task automatic checkFlag(input string what, input bit exp, input bit act);
    if (act !== exp) begin
      $display("ERR %s %s expected %0b actual %0b", testName, what, exp, act);
      abortRun();
    end
  endtask

  // Limit grows with each line that is sent
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Timeout after %0d cycles with the load stream unfinished", cycles);
      abortRun();
    end
  end

  // Mid-cycle monitor for write starts, write phases and flag pulses
  always @(negedge clk) begin
    if (cksumErr) begin
      cksumCnt++;
    end
    if (formatErr) begin
      formatCnt++;
    end
    if (loadDone) begin
      doneCnt++;
    end
    if (writePhase < 3) begin
      // Second strobe cycle, then the driven cycle, then the idle cycle
      writePhase++;
      checkFlag("diagStrobe", writePhase == 1, diag.diagStrobe);
      checkFlag("driving", writePhase < 3, diag.driving);
    end else if (diag.diagStrobe) begin
      if (expWrites.size() == 0) begin
        $display("Bus write with function %o appeared when none was due", diag.func);
        abortRun();
      end else begin
        checkDiag(expWrites.pop_front(), diag);
      end
      writePhase = 0;
    end
  end

  //////////////////////////////////////////////////
  // Send the built line with random gaps then check its flags
  task automatic sendLine();
    int gap;
    int c0;
    int f0;
    int d0;
    cycleLimit += lineChars.size() * 4 + lineCram * 28;
    c0 = cksumCnt;
    f0 = formatCnt;
    d0 = doneCnt;
    foreach (lineChars[i]) begin
      if ($urandom % 4 == 0) begin
        charValid = 1'b0;
        gap       = 1 + $urandom % 2;
        repeat (gap) @(negedge clk);
      end
      charValid = 1'b1;
      charIn    = lineChars[i];
      // Held while the parser waits on the writer
      while (!charReady) begin
        @(negedge clk);
      end
      @(negedge clk);
    end
    charValid = 1'b0;
    // Decoder and parser add one cycle each before a line flag
    repeat (3) @(negedge clk);
    checkFlag("cksumErr", expCksum, cksumCnt != c0);
    checkFlag("formatErr", expFormat, formatCnt != f0);
    checkFlag("loadDone", expDone, doneCnt != d0);
  endtask

  function automatic ucodePkg::word_t randomAdr();
    if ($urandom % 2 == 0) begin
      randomAdr = '0;
    end else begin
      randomAdr = ucodePkg::word_t'(1 + $urandom % 2047);
    end
  endfunction

  function automatic logic [`UCODE_CHAR_W-1:0] skipType();
    case ($urandom % 3)
      0: skipType = `UCODE_CH_D;
      1: skipType = `UCODE_CH_Z;
      default: skipType = `UCODE_CH_SEMI;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Test sequence
  initial begin
    void'($urandom(32'h9b9270c6));
    rstN       = 1'b0;
    charValid  = 1'b0;
    charIn     = '0;
    nextAdr    = '0;
    expVersion = '0;
    expSeenLo  = 1'b0;
    expSeenHi  = 1'b0;
    testName   = "reset";
    repeat (2) @(negedge clk);
    rstN = 1'b1;
    checkFlag("charReady", 1'b1, charReady);
    checkFlag("diagStrobe", 1'b0, diag.diagStrobe);
    checkFlag("driving", 1'b0, diag.driving);
    checkFlag("loadDone", 1'b0, loadDone);
    checkFlag("cksumErr", 1'b0, cksumErr);
    checkFlag("formatErr", 1'b0, formatErr);
    checkFlag("versionValid", 1'b0, versionValid);

    testName = "single word";
    buildCramLine(16'o200, 1, 1'b0);
    sendLine();

    // Zero address picks up after the last word
    testName = "address continuation";
    buildCramLine('0, 3, 1'b0);
    sendLine();
    buildCramLine(16'o400, 5, 1'b0);
    sendLine();
    buildCramLine('0, 2, 1'b0);
    sendLine();

    testName = "bad checksum";
    buildCramLine('0, 1, 1'b1);
    sendLine();

    testName = "skipped lines";
    buildOtherLine(`UCODE_CH_D, 5, 1'b0);
    sendLine();
    buildOtherLine(`UCODE_CH_Z, 2, 1'b0);
    sendLine();
    buildOtherLine(`UCODE_CH_SEMI, 3, 1'b0);
    sendLine();

    testName = "format errors";
    buildOtherLine(7'o121, 3, 1'b1);
    sendLine();
    buildBadCountLine();
    sendLine();

    testName = "version words";
    buildCramLine(16'o136, 2, 1'b0);
    sendLine();

    testName = "random lines";
    for (n = 0; n < 24; n++) begin
      case ($urandom % 6)
        0, 1, 2: buildCramLine(randomAdr(), 1 + $urandom % 5, ($urandom % 5) == 0);
        3:       buildOtherLine(skipType(), 1 + $urandom % 8, 1'b0);
        4:       buildOtherLine(7'o101 + 7'($urandom % 2), 1 + $urandom % 4, 1'b1);
        default: buildBadCountLine();
      endcase
      sendLine();
    end

    testName = "end record";
    buildEndLine();
    sendLine();
    // Last write is over once driving drops with nothing left due
    while (expWrites.size() != 0 || diag.driving) begin
      @(negedge clk);
    end

    testName = "version";
    checkFlag("versionValid", expSeenLo && expSeenHi, versionValid);
    checkVersion(expVersion, version);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
+incdir+tb
logic/ucodePkg.sv
logic/sixbitDecoder.sv
logic/recordParser.sv
logic/cramWriter.sv
logic/ucodeLoader.sv
tb/ucodeLoaderTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
# The run passes only when the simulation output holds the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module ucodeLoaderTb &&
./obj_dir/VucodeLoaderTb | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
